// File: pcoeffPkg.sv
`default_nettype none

package pcoeffPkg;

    // Function and lattice geometry
    localparam int funcWidth = 128;         // One bit per truth-table index of 7 variables
    localparam int varCount = 7;            // Index width, also the hypercube dimension
    localparam int permCount = 6;           // Arrangements of variables 4, 5 and 6

    // Result widths
    localparam int compWidth = 7;           // Holds a component count up to 64
    localparam int maxComponents = 64;      // Checkerboard set is the worst case
    localparam int sumWidth = 38;
    localparam int countWidth = 3;

    localparam int fifoDepth = 4;           // Used by both stage FIFOs

    // Entry k lists where variables 4, 5 and 6 land under permutation k
    // Rows follow the lexicographic order of the arrangements of {4,5,6}
    localparam int permTable [permCount][3] = '{
        '{4, 5, 6},                         // Identity
        '{4, 6, 5},
        '{5, 4, 6},
        '{5, 6, 4},
        '{6, 4, 5},
        '{6, 5, 4}
    };

    // Input FIFO payload
    typedef struct packed {
        logic                 startNewTop;  // Load func as the new top first
        logic [funcWidth-1:0] func;
    } inItem;

    // Output FIFO payload with the sum above the count
    typedef struct packed {
        logic [sumWidth-1:0]   sum;
        logic [countWidth-1:0] count;
    } outItem;

endpackage

`default_nettype wire

// File: pipeFifo.sv
`timescale 1ns/10ps
`default_nettype none

module pipeFifo #(
    parameter type payloadT = logic
) (
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire logic    inValid,
    output logic         inReady,
    input  wire payloadT inData,
    output logic         outValid,
    input  wire logic    outReady,
    output payloadT      outData
);

    localparam int ptrWidth = $clog2(pcoeffPkg::fifoDepth);
    localparam int occWidth = $clog2(pcoeffPkg::fifoDepth + 1);

    payloadT mem [pcoeffPkg::fifoDepth];    // Entry storage

    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth-1:0] wrPtr;
    logic [occWidth-1:0] occupancy;
    logic                wrEn;
    logic                rdEn;

    assign inReady = (occupancy != occWidth'(pcoeffPkg::fifoDepth));
    assign outValid = (occupancy != '0);
    assign outData = mem[rdPtr];            // Head entry is always on the output
    assign wrEn = inValid && inReady;
    assign rdEn = outValid && outReady;

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrPtr] <= inData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            occupancy <= '0;
        end else begin
            if (wrEn) begin
                wrPtr <= (wrPtr == ptrWidth'(pcoeffPkg::fifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (rdEn) begin
                rdPtr <= (rdPtr == ptrWidth'(pcoeffPkg::fifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            occupancy <= occupancy + occWidth'(wrEn) - occWidth'(rdEn);
        end
    end

    // A write refused by the full buffer stays offered unchanged until it is taken
    noOverflow: assert property (@(posedge clk) disable iff (!rst)
        (inValid && !inReady) |=> (inValid && $stable(inData)));

endmodule

`default_nettype wire

// File: variableSwapper.sv
`timescale 1ns/10ps
`default_nettype none

module variableSwapper (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           inValid,
    output logic                                inReady,
    input  wire logic                           startNewTop,
    input  wire logic [pcoeffPkg::funcWidth-1:0] bot,
    output logic                                permValid,
    input  wire logic                           permReady,
    output logic [pcoeffPkg::funcWidth-1:0]     permBot,
    output logic [pcoeffPkg::funcWidth-1:0]     top,
    output logic                                permFirst,
    output logic                                permLast
);

    logic                           busy;   // Set while permutations are pending
    logic [2:0]                     permIdx;
    logic [pcoeffPkg::funcWidth-1:0] topReg;
    logic [pcoeffPkg::funcWidth-1:0] botReg;

    // Moves bits 4..6 of a truth-table index to their permuted positions
    function automatic logic [pcoeffPkg::varCount-1:0] permuteIndex(
        input logic [pcoeffPkg::varCount-1:0] idx,
        input logic [2:0]                     k
    );
        logic [pcoeffPkg::varCount-1:0] res;
        res = idx;
        for (int j = 0; j < 3; j++) begin
            res[pcoeffPkg::permTable[k][j]] = idx[4 + j];
        end
        return res;
    endfunction

    assign inReady = !busy;
    assign permValid = busy;
    assign top = topReg;
    assign permFirst = (permIdx == 3'd0);
    assign permLast = (permIdx == 3'(pcoeffPkg::permCount - 1));

    always_comb begin
        permBot = '0;
        for (int i = 0; i < pcoeffPkg::funcWidth; i++) begin
            permBot[permuteIndex(pcoeffPkg::varCount'(i), permIdx)] = botReg[i];
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            botReg <= bot;
            if (startNewTop) begin
                topReg <= bot;              // New top applies to this bot too
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            permIdx <= '0;
        end else if (inValid && inReady) begin
            busy <= 1'b1;
            permIdx <= '0;
        end else if (permValid && permReady) begin
            if (permLast) begin
                busy <= 1'b0;               // Free for the next item
            end else begin
                permIdx <= permIdx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: componentCounter.sv
`timescale 1ns/10ps
`default_nettype none

module componentCounter (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            permValid,
    output logic                                 permReady,
    input  wire logic [pcoeffPkg::funcWidth-1:0] permBot,
    input  wire logic [pcoeffPkg::funcWidth-1:0] top,
    input  wire logic                            permFirst,
    input  wire logic                            permLast,
    output logic                                 compValid,
    input  wire logic                            compReady,
    output logic [pcoeffPkg::compWidth-1:0]      compCount,
    output logic                                 compQualified,
    output logic                                 compFirst,
    output logic                                 compLast
);

    typedef enum logic [1:0] {stIdle, stCheck, stGrow, stDone} stateT;

    stateT                           state;
    logic [pcoeffPkg::funcWidth-1:0] remaining;  // Vertices not yet assigned to a component
    logic [pcoeffPkg::funcWidth-1:0] frontier;   // Component being flooded
    logic                            outside;    // Bot has a bit that top lacks
    logic [pcoeffPkg::funcWidth-1:0] grown;
    logic [pcoeffPkg::funcWidth-1:0] leftover;

    // Adds every index one bit flip away from a member
    function automatic logic [pcoeffPkg::funcWidth-1:0] growStep(
        input logic [pcoeffPkg::funcWidth-1:0] f
    );
        logic [pcoeffPkg::funcWidth-1:0] res;
        res = f;
        for (int i = 0; i < pcoeffPkg::funcWidth; i++) begin
            for (int b = 0; b < pcoeffPkg::varCount; b++) begin
                res[i] = res[i] | f[i ^ (1 << b)];
            end
        end
        return res;
    endfunction

    assign grown = growStep(frontier) & remaining;
    assign leftover = remaining & ~frontier;
    assign permReady = (state == stIdle);
    assign compValid = (state == stDone);

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= stIdle;
        end else begin
            case (state)
                stIdle: begin
                    if (permValid) begin
                        remaining <= top & ~permBot;
                        outside <= |(permBot & ~top);
                        compFirst <= permFirst;
                        compLast <= permLast;
                        state <= stCheck;
                    end
                end
                stCheck: begin
                    compCount <= '0;
                    compQualified <= !outside;
                    if (outside || remaining == '0) begin
                        state <= stDone;    // Nothing to flood
                    end else begin
                        frontier <= remaining & (~remaining + 1'b1); // Lowest set index
                        state <= stGrow;
                    end
                end
                stGrow: begin
                    if (grown == frontier) begin
                        // The finished component leaves the set and the next one is seeded
                        compCount <= compCount + 1'b1;
                        remaining <= leftover;
                        frontier <= leftover & (~leftover + 1'b1);
                        if (leftover == '0) begin
                            state <= stDone;
                        end
                    end else begin
                        frontier <= grown;
                    end
                end
                stDone: begin
                    if (compReady) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    // A 7-cube holds at most 64 separate components
    countLimit: assert property (@(posedge clk) disable iff (!rst)
        state == stGrow |-> compCount < pcoeffPkg::compWidth'(pcoeffPkg::maxComponents));

endmodule

`default_nettype wire

// File: pcoeffAccumulator.sv
`timescale 1ns/10ps
`default_nettype none

module pcoeffAccumulator (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            compValid,
    output logic                                 compReady,
    input  wire logic [pcoeffPkg::compWidth-1:0] compCount,
    input  wire logic                            compQualified,
    input  wire logic                            compFirst,
    input  wire logic                            compLast,
    output logic                                 resValid,
    input  wire logic                            resReady,
    output logic [pcoeffPkg::sumWidth-1:0]       summedData,
    output logic [pcoeffPkg::countWidth-1:0]     pcoeffCount
);

    logic                              compXfer;
    logic [pcoeffPkg::sumWidth-1:0]    power;     // Two to the component count
    logic [pcoeffPkg::sumWidth-1:0]    baseSum;
    logic [pcoeffPkg::countWidth-1:0]  baseCount;

    // Stall only while a finished result is still waiting
    assign compReady = !resValid || resReady;
    assign compXfer = compValid && compReady;
    assign power = {{(pcoeffPkg::sumWidth - 1){1'b0}}, 1'b1} << compCount;
    assign baseSum = compFirst ? '0 : summedData;
    assign baseCount = compFirst ? '0 : pcoeffCount;

    always_ff @(posedge clk) begin
        if (compXfer) begin
            if (compQualified) begin
                summedData <= baseSum + power;
                pcoeffCount <= baseCount + 1'b1;
            end else begin
                summedData <= baseSum;
                pcoeffCount <= baseCount;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            resValid <= 1'b0;
        end else if (compXfer) begin
            resValid <= compLast;           // Result ready after the sixth permutation
        end else if (resReady) begin
            resValid <= 1'b0;
        end
    end

    // Six permutations per bot bound the qualifying count
    countBound: assert property (@(posedge clk) disable iff (!rst)
        resValid |-> pcoeffCount <= pcoeffPkg::countWidth'(pcoeffPkg::permCount));

endmodule

`default_nettype wire

// File: pcoeffPipeline.sv
`timescale 1ns/10ps
`default_nettype none

module pcoeffPipeline (
    input  wire logic                            clk,
    input  wire logic                            rst,
    input  wire logic                            inValid,
    output logic                                 inReady,
    input  wire logic                            startNewTop,
    input  wire logic [pcoeffPkg::funcWidth-1:0] bot,
    output logic                                 outValid,
    input  wire logic                            outReady,
    output logic [pcoeffPkg::sumWidth-1:0]       summedData,
    output logic [pcoeffPkg::countWidth-1:0]     pcoeffCount
);

    pcoeffPkg::inItem  inFifoIn;
    pcoeffPkg::inItem  inFifoOut;
    pcoeffPkg::outItem outFifoIn;
    pcoeffPkg::outItem outFifoOut;

    logic                              itemValid;
    logic                              itemReady;
    logic                              permValid;
    logic                              permReady;
    logic [pcoeffPkg::funcWidth-1:0]   permBot;
    logic [pcoeffPkg::funcWidth-1:0]   top;
    logic                              permFirst;
    logic                              permLast;
    logic                              compValid;
    logic                              compReady;
    logic [pcoeffPkg::compWidth-1:0]   compCount;
    logic                              compQualified;
    logic                              compFirst;
    logic                              compLast;
    logic                              resValid;
    logic                              resReady;
    logic [pcoeffPkg::sumWidth-1:0]    resSum;
    logic [pcoeffPkg::countWidth-1:0]  resCount;

    assign inFifoIn = '{startNewTop: startNewTop, func: bot};
    assign outFifoIn = '{sum: resSum, count: resCount};
    assign summedData = outFifoOut.sum;
    assign pcoeffCount = outFifoOut.count;

    pipeFifo #(.payloadT(pcoeffPkg::inItem)) inFifo (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inReady(inReady), .inData(inFifoIn),
        .outValid(itemValid), .outReady(itemReady), .outData(inFifoOut)
    );

    variableSwapper swapper (
        .clk(clk), .rst(rst),
        .inValid(itemValid), .inReady(itemReady),
        .startNewTop(inFifoOut.startNewTop), .bot(inFifoOut.func),
        .permValid(permValid), .permReady(permReady), .permBot(permBot),
        .top(top), .permFirst(permFirst), .permLast(permLast)
    );

    componentCounter counter (
        .clk(clk), .rst(rst),
        .permValid(permValid), .permReady(permReady), .permBot(permBot), .top(top),
        .permFirst(permFirst), .permLast(permLast),
        .compValid(compValid), .compReady(compReady), .compCount(compCount),
        .compQualified(compQualified), .compFirst(compFirst), .compLast(compLast)
    );

    pcoeffAccumulator accumulator (
        .clk(clk), .rst(rst),
        .compValid(compValid), .compReady(compReady), .compCount(compCount),
        .compQualified(compQualified), .compFirst(compFirst), .compLast(compLast),
        .resValid(resValid), .resReady(resReady),
        .summedData(resSum), .pcoeffCount(resCount)
    );

    pipeFifo #(.payloadT(pcoeffPkg::outItem)) outFifo (
        .clk(clk), .rst(rst),
        .inValid(resValid), .inReady(resReady), .inData(outFifoIn),
        .outValid(outValid), .outReady(outReady), .outData(outFifoOut)
    );

endmodule

`default_nettype wire

// File: pcoeffModel.svh
`ifndef pcoeffModelSvh
`define pcoeffModelSvh

// Bit position that variable 4+j moves to under arrangement k,
// where arrangements of {4,5,6} are ranked in lexicographic order
function automatic int arrangedPosition(input int k, input int j);
    int rank;
    int pos [3];
    rank = 0;
    for (int a = 4; a <= 6; a++) begin
        for (int b = 4; b <= 6; b++) begin
            for (int c = 4; c <= 6; c++) begin
                if (a != b && a != c && b != c) begin
                    if (rank == k) begin
                        pos[0] = a;
                        pos[1] = b;
                        pos[2] = c;
                    end
                    rank++;
                end
            end
        end
    end
    return pos[j];
endfunction

function automatic logic [pcoeffPkg::funcWidth-1:0] permuteFunc(
    input logic [pcoeffPkg::funcWidth-1:0] f,
    input int                              k
);
    logic [pcoeffPkg::funcWidth-1:0] res;
    logic [6:0]                      idx;
    logic [6:0]                      moved;
    res = '0;
    for (int i = 0; i < pcoeffPkg::funcWidth; i++) begin
        idx = 7'(i);
        moved = idx;
        for (int j = 0; j < 3; j++) begin
            moved[arrangedPosition(k, j)] = idx[4 + j];
        end
        res[moved] = f[i];                  // Bit i of the source lands on bit p(i)
    end
    return res;
endfunction

function automatic logic isSubset(
    input logic [pcoeffPkg::funcWidth-1:0] sub,
    input logic [pcoeffPkg::funcWidth-1:0] sup
);
    return (sub & ~sup) == '0;
endfunction

// Depth-first search over the 7-cube with one stack entry per reached vertex
function automatic int countComponents(input logic [pcoeffPkg::funcWidth-1:0] set);
    logic [pcoeffPkg::funcWidth-1:0] seen;
    int                              stack [$];
    int                              v;
    int                              n;
    int                              count;
    seen = '0;
    count = 0;
    for (int s = 0; s < pcoeffPkg::funcWidth; s++) begin
        if (set[s] && !seen[s]) begin
            count++;                        // Unseen vertex starts a new component
            seen[s] = 1'b1;
            stack.push_back(s);
            while (stack.size() > 0) begin
                v = stack.pop_back();
                for (int b = 0; b < 7; b++) begin
                    n = v ^ (1 << b);
                    if (set[n] && !seen[n]) begin
                        seen[n] = 1'b1;
                        stack.push_back(n);
                    end
                end
            end
        end
    end
    return count;
endfunction

function automatic pcoeffPkg::outItem expectedResult(
    input logic [pcoeffPkg::funcWidth-1:0] top,
    input logic [pcoeffPkg::funcWidth-1:0] bot
);
    pcoeffPkg::outItem               res;
    logic [pcoeffPkg::funcWidth-1:0] permBot;
    res = '0;
    for (int k = 0; k < pcoeffPkg::permCount; k++) begin
        permBot = permuteFunc(bot, k);
        if (isSubset(permBot, top)) begin
            res.sum = res.sum + (pcoeffPkg::sumWidth'(1) << countComponents(top & ~permBot));
            res.count = res.count + 1'b1;
        end
    end
    return res;
endfunction

`endif

// File: pcoeffPipelineTb.sv
`timescale 1ns/10ps
`default_nettype none

module pcoeffPipelineTb;

    localparam int clkPeriod = 20;
    localparam int itemTotal = 75;          // Items sent over all tests
    localparam int watchdogNs = itemTotal * pcoeffPkg::permCount * 70 * clkPeriod;

    logic                              clk;
    logic                              rst;
    logic                              inValid;
    logic                              inReady;
    logic                              startNewTop;
    logic [pcoeffPkg::funcWidth-1:0]   bot;
    logic                              outValid;
    logic                              outReady;
    logic [pcoeffPkg::sumWidth-1:0]    summedData;
    logic [pcoeffPkg::countWidth-1:0]  pcoeffCount;

    logic [15:0]                       lfsrState = 16'd19;
    pcoeffPkg::outItem                 expected [$];
    logic [pcoeffPkg::funcWidth-1:0]   curTop = '0;
    int errorCount = 0;
    int sentCount = 0;
    int receivedCount = 0;
    int testCount = 0;
    int failedTests = 0;

    `include "pcoeffModel.svh"

    pcoeffPipeline DUT (
        .clk(clk), .rst(rst),
        .inValid(inValid), .inReady(inReady), .startNewTop(startNewTop), .bot(bot),
        .outValid(outValid), .outReady(outReady),
        .summedData(summedData), .pcoeffCount(pcoeffCount)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic randomBit();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    function automatic logic [pcoeffPkg::funcWidth-1:0] randomBits(input int n);
        logic [pcoeffPkg::funcWidth-1:0] res;
        res = '0;
        for (int i = 0; i < n; i++) begin
            res = {res[pcoeffPkg::funcWidth-2:0], randomBit()};
        end
        return res;
    endfunction

    // Depends only on the weight of variables 4..6, so every arrangement keeps it
    function automatic logic [pcoeffPkg::funcWidth-1:0] symmetricTop();
        logic [pcoeffPkg::funcWidth-1:0] res;
        for (int i = 0; i < pcoeffPkg::funcWidth; i++) begin
            res[i] = ((i & 15) % 3 == 0) ^ ((((i >> 4) & 1) + ((i >> 5) & 1) + ((i >> 6) & 1)) == 2);
        end
        return res;
    endfunction

    task automatic checkValue(input string name, input logic [63:0] want, input logic [63:0] got);
        if (want !== got) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, want, got);
            errorCount++;
        end
    endtask

    // Returns at the falling edge before the transfer edge
    task automatic sendItem(input logic newTop, input logic [pcoeffPkg::funcWidth-1:0] value,
                            input logic stress);
        if (newTop) begin
            curTop = value;
        end
        expected.push_back(expectedResult(curTop, value));
        sentCount++;
        while (stress && !randomBit()) begin
            @(posedge clk);
            inValid <= 1'b0;                // Idle cycle between items
            outReady <= randomBit();
        end
        @(posedge clk);
        inValid <= 1'b1;
        startNewTop <= newTop;
        bot <= value;
        if (stress) begin
            outReady <= randomBit();
        end
        @(negedge clk);
        while (!inReady) begin
            @(posedge clk);
            if (stress) begin
                outReady <= randomBit();
            end
            @(negedge clk);
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        @(posedge clk);
        inValid <= 1'b0;
        outReady <= 1'b1;
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        checkValue("resultCount", sentCount, receivedCount);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("Test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
        end
    endtask

    // Each falling edge with valid and ready high precedes one output transfer
    initial begin
        pcoeffPkg::outItem head;
        forever begin
            @(negedge clk);
            if (outValid && outReady) begin
                receivedCount++;
                if (expected.size() == 0) begin
                    $display("Result at %0t arrived with no input pending", $time);
                    errorCount++;
                end else begin
                    head = expected.pop_front();
                    checkValue("summedData", head.sum, summedData);
                    checkValue("pcoeffCount", head.count, pcoeffCount);
                end
            end
        end
    end

    initial begin
        #(watchdogNs);
        $display("Run timed out with %0d results missing", expected.size());
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [pcoeffPkg::funcWidth-1:0] top;
        logic [pcoeffPkg::funcWidth-1:0] b;
        pcoeffPkg::outItem               model;
        int                              mark;
        rst <= 1'b0;
        inValid <= 1'b0;
        startNewTop <= 1'b0;
        bot <= '0;
        outReady <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b1;

        mark = errorCount;
        repeat (4) begin
            @(negedge clk);
            checkValue("outValid", 0, outValid);
            checkValue("inReady", 1, inReady);
        end
        finishTest("after reset", mark);

        mark = errorCount;
        top = symmetricTop();
        model = expectedResult(top, top);
        checkValue("modelSum", 6, model.sum);
        checkValue("modelCount", 6, model.count);
        sendItem(1'b1, top, 1'b0);
        sendItem(1'b0, top, 1'b0);
        finishTest("bot equal to top", mark);

        mark = errorCount;
        top = randomBits(pcoeffPkg::funcWidth) & ~pcoeffPkg::funcWidth'(1);
        sendItem(1'b1, top, 1'b0);
        repeat (4) begin
            b = (top & randomBits(pcoeffPkg::funcWidth)) | pcoeffPkg::funcWidth'(1);
            model = expectedResult(top, b);  // Index 0 is fixed by every arrangement
            checkValue("modelSum", 0, model.sum);
            checkValue("modelCount", 0, model.count);
            sendItem(1'b0, b, 1'b0);
        end
        finishTest("bots outside the top", mark);

        mark = errorCount;
        repeat (4) begin
            top = randomBits(pcoeffPkg::funcWidth) & randomBits(pcoeffPkg::funcWidth);
            sendItem(1'b1, top, 1'b0);
            repeat (8) sendItem(1'b0, top & randomBits(pcoeffPkg::funcWidth), 1'b0);
        end
        finishTest("random bots", mark);

        mark = errorCount;
        repeat (2) begin
            top = randomBits(pcoeffPkg::funcWidth) & randomBits(pcoeffPkg::funcWidth);
            sendItem(1'b1, top, 1'b1);
            repeat (15) sendItem(1'b0, top & randomBits(pcoeffPkg::funcWidth), 1'b1);
        end
        finishTest("back-pressure", mark);

        $display("Summary: %0d tests, %0d failed, %0d sent, %0d received, %0d errors",
                 testCount, failedTests, sentCount, receivedCount, errorCount);
        if (errorCount == 0 && failedTests == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pcoeffPipeline.f
+incdir+.
pcoeffPkg.sv
pipeFifo.sv
variableSwapper.sv
componentCounter.sv
pcoeffAccumulator.sv
pcoeffPipeline.sv
pcoeffPipelineTb.sv
